// ==== design/lcd_settings.svh ====
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus and counter widths
////////////////////////////////////////////////////////////////////////////

`define LCD_DATA_W 4
`define LCD_DELAY_W 20

////////////////////////////////////////////////////////////////////////////
// Enable pulse timing in 50 MHz cycles
////////////////////////////////////////////////////////////////////////////

`define LCD_SETUP_CYCLES 2
`define LCD_E_PULSE_CYCLES 12
`define LCD_HOLD_CYCLES 1
`define LCD_NIBBLE_GAP 50

////////////////////////////////////////////////////////////////////////////
// Settle delays after each step
////////////////////////////////////////////////////////////////////////////

// 15 ms power-up
`define LCD_POWER_UP_WAIT 750000
`define LCD_WAKE1_WAIT 205000
`define LCD_WAKE2_WAIT 5000
`define LCD_CMD_WAIT 2000
// Clear needs 1.64 ms
`define LCD_CLEAR_WAIT 82000

// Power-on table and screen sizes
`define LCD_INIT_STEPS 9
`define LCD_SCREEN_MAX 34
`define LCD_INDEX_W 6

`endif

// ==== design/lcd_pkg.sv ====
`include "lcd_settings.svh"

package lcd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Steps handed to the bus writer
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		STEP_WAIT,
		STEP_NIBBLE,
		STEP_BYTE
	} step_kind_t;

	// Nibble steps use payload[3:0] only
	typedef struct packed {
		step_kind_t kind;
		logic rs;
		logic [7:0] payload;
		logic [`LCD_DELAY_W-1:0] post_wait;
	} lcd_step_t;

	////////////////////////////////////////////////////////////////////////////
	// Pins and screens
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic e;
		logic rs;
		logic [`LCD_DATA_W-1:0] data;
	} lcd_bus_t;

	typedef enum logic [1:0] {
		SCREEN_TITLE,
		SCREEN_TWO,
		SCREEN_THREE,
		SCREEN_FOUR
	} screen_t;

endpackage

// ==== design/lcd_delay_timer.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_delay_timer (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [`LCD_DELAY_W-1:0] count,
	output logic expired
);

	logic [`LCD_DELAY_W-1:0] remaining;

	// Loading count-1 lets expired rise count cycles after load
	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
		end
		else if (load) begin
			remaining <= count - 1'b1;
		end
		else if (remaining != '0) begin
			remaining <= remaining - 1'b1;
		end
	end

	// Stays high until the next load
	assign expired = (remaining == '0);

	// A zero count would wrap to the full range
	assert property (@(posedge clk) disable iff (reset)
		load |-> count != '0)
		else $error("delay timer loaded with zero count");

endmodule

// ==== design/lcd_bus_writer.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_bus_writer import lcd_pkg::*; (
	input logic clk,
	input logic reset,
	input lcd_step_t step,
	input logic step_start,
	output logic step_done,
	output lcd_bus_t lcd
);

	localparam logic [`LCD_DELAY_W-1:0] SETUP_WAIT = `LCD_DELAY_W'(`LCD_SETUP_CYCLES);
	localparam logic [`LCD_DELAY_W-1:0] PULSE_WAIT = `LCD_DELAY_W'(`LCD_E_PULSE_CYCLES);
	localparam logic [`LCD_DELAY_W-1:0] HOLD_WAIT = `LCD_DELAY_W'(`LCD_HOLD_CYCLES);
	localparam logic [`LCD_DELAY_W-1:0] GAP_WAIT = `LCD_DELAY_W'(`LCD_NIBBLE_GAP);

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_SETUP,
		PH_PULSE,
		PH_HOLD,
		PH_GAP,
		PH_POST
	} phase_t;

	phase_t phase;
	lcd_step_t cur;
	logic low_half;

	logic load;
	logic [`LCD_DELAY_W-1:0] count;
	logic expired;

	lcd_delay_timer timer (
		.clk(clk),
		.reset(reset),
		.load(load),
		.count(count),
		.expired(expired)
	);

	////////////////////////////////////////////////////////////////////////////
	// Timer reload on every phase change
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		load = 1'b0;
		count = SETUP_WAIT;
		case (phase)
			PH_IDLE: begin
				if (step_start) begin
					load = 1'b1;
					count = (step.kind == STEP_WAIT) ? step.post_wait : SETUP_WAIT;
				end
			end
			PH_SETUP: begin
				load = expired;
				count = PULSE_WAIT;
			end
			PH_PULSE: begin
				load = expired;
				count = HOLD_WAIT;
			end
			PH_HOLD: begin
				load = expired;
				// Upper nibble of a byte is followed by the gap
				if (cur.kind == STEP_BYTE && !low_half) begin
					count = GAP_WAIT;
				end
				else begin
					count = cur.post_wait;
				end
			end
			PH_GAP: begin
				load = expired;
				count = SETUP_WAIT;
			end
			default: begin
				load = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (phase == PH_IDLE && step_start) begin
			cur <= step;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= PH_IDLE;
			low_half <= 1'b0;
			step_done <= 1'b0;
			lcd <= '0;
		end
		else begin
			step_done <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (step_start) begin
						low_half <= 1'b0;
						if (step.kind == STEP_WAIT) begin
							phase <= PH_POST;
						end
						else begin
							lcd.rs <= step.rs;
							lcd.data <= (step.kind == STEP_BYTE) ? step.payload[7:4]
								: step.payload[3:0];
							phase <= PH_SETUP;
						end
					end
				end
				PH_SETUP: begin
					if (expired) begin
						lcd.e <= 1'b1;
						phase <= PH_PULSE;
					end
				end
				PH_PULSE: begin
					if (expired) begin
						lcd.e <= 1'b0;
						phase <= PH_HOLD;
					end
				end
				PH_HOLD: begin
					if (expired) begin
						phase <= (cur.kind == STEP_BYTE && !low_half) ? PH_GAP : PH_POST;
					end
				end
				PH_GAP: begin
					if (expired) begin
						lcd.data <= cur.payload[3:0];
						low_half <= 1'b1;
						phase <= PH_SETUP;
					end
				end
				default: begin
					if (expired) begin
						step_done <= 1'b1;
						phase <= PH_IDLE;
					end
				end
			endcase
		end
	end

	// LCD latches on the falling edge of e
	assert property (@(posedge clk) disable iff (reset)
		$past(lcd.e) |-> $stable({lcd.rs, lcd.data}))
		else $error("rs or data moved while e was high");

	assert property (@(posedge clk) disable iff (reset)
		step_start |-> phase == PH_IDLE)
		else $error("step_start while a step is in flight");

endmodule

// ==== design/lcd_screen_rom.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_screen_rom import lcd_pkg::*; (
	input screen_t screen,
	input logic [`LCD_INDEX_W-1:0] index,
	output lcd_step_t entry,
	output logic last
);

	localparam int LINE_LEN = 16;
	localparam int DIGIT_LEN = 2;
	localparam logic [7:0] CMD_HOME = 8'h02;
	localparam logic [7:0] CMD_LINE2 = 8'hC0;
	localparam logic [8*LINE_LEN-1:0] TITLE_TOP = " BinToDec Spele ";
	localparam logic [8*LINE_LEN-1:0] TITLE_BOTTOM = "<Sakt           ";

	logic [3:0] col;
	logic [7:0] digit;

	function automatic lcd_step_t make_byte(input logic rs, input logic [7:0] value);
		lcd_step_t s;
		s.kind = STEP_BYTE;
		s.rs = rs;
		s.payload = value;
		s.post_wait = `LCD_DELAY_W'(`LCD_CMD_WAIT);
		return s;
	endfunction

	// Screen n shows digit n+1
	assign digit = 8'h30 + 8'(screen) + 8'd1;

	always_comb begin
		col = '0;
		entry = make_byte(1'b1, " ");
		last = 1'b0;
		case (screen)
			SCREEN_TITLE: begin
				last = (index == `LCD_SCREEN_MAX - 1);
				if (index == 0) begin
					entry = make_byte(1'b0, CMD_HOME);
				end
				else if (index <= LINE_LEN) begin
					col = 4'(index - 1);
					entry = make_byte(1'b1, TITLE_TOP[8*(LINE_LEN-1-col) +: 8]);
				end
				else if (index == LINE_LEN + 1) begin
					entry = make_byte(1'b0, CMD_LINE2);
				end
				else begin
					col = 4'(index - (LINE_LEN + 2));
					entry = make_byte(1'b1, TITLE_BOTTOM[8*(LINE_LEN-1-col) +: 8]);
				end
			end
			default: begin
				last = (index == DIGIT_LEN - 1);
				if (index == 0) begin
					entry = make_byte(1'b0, CMD_HOME);
				end
				else begin
					entry = make_byte(1'b1, digit);
				end
			end
		endcase
	end

endmodule

// ==== design/lcd_sequencer.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_sequencer import lcd_pkg::*; (
	input logic clk,
	input logic reset,
	input screen_t game_state,
	output lcd_step_t step,
	output logic step_start,
	input logic step_done,
	output screen_t screen,
	output logic [`LCD_INDEX_W-1:0] index,
	input lcd_step_t rom_entry,
	input logic rom_last
);

	typedef enum logic [2:0] {
		SQ_BOOT,
		SQ_INIT,
		SQ_LOAD,
		SQ_STREAM,
		SQ_IDLE
	} seq_state_t;

	seq_state_t state;
	logic [3:0] init_idx;

	function automatic lcd_step_t make_step(input step_kind_t kind, input logic [7:0] value,
		input logic [`LCD_DELAY_W-1:0] wait_cycles);
		lcd_step_t s;
		s.kind = kind;
		s.rs = 1'b0;
		s.payload = value;
		s.post_wait = wait_cycles;
		return s;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Power-on table of 4-bit mode entry and setup commands
	////////////////////////////////////////////////////////////////////////////

	function automatic lcd_step_t init_entry(input logic [3:0] n);
		case (n)
			4'd0: return make_step(STEP_WAIT, 8'h00, `LCD_DELAY_W'(`LCD_POWER_UP_WAIT));
			4'd1: return make_step(STEP_NIBBLE, 8'h03, `LCD_DELAY_W'(`LCD_WAKE1_WAIT));
			4'd2: return make_step(STEP_NIBBLE, 8'h03, `LCD_DELAY_W'(`LCD_WAKE2_WAIT));
			4'd3: return make_step(STEP_NIBBLE, 8'h03, `LCD_DELAY_W'(`LCD_CMD_WAIT));
			4'd4: return make_step(STEP_NIBBLE, 8'h02, `LCD_DELAY_W'(`LCD_CMD_WAIT));
			4'd5: return make_step(STEP_BYTE, 8'h28, `LCD_DELAY_W'(`LCD_CMD_WAIT));
			4'd6: return make_step(STEP_BYTE, 8'h06, `LCD_DELAY_W'(`LCD_CMD_WAIT));
			4'd7: return make_step(STEP_BYTE, 8'h0C, `LCD_DELAY_W'(`LCD_CMD_WAIT));
			default: return make_step(STEP_BYTE, 8'h01, `LCD_DELAY_W'(`LCD_CLEAR_WAIT));
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SQ_BOOT;
			init_idx <= '0;
			step <= '0;
			step_start <= 1'b0;
			screen <= SCREEN_TITLE;
			index <= '0;
		end
		else begin
			step_start <= 1'b0;
			case (state)
				SQ_BOOT: begin
					step <= init_entry(4'd0);
					step_start <= 1'b1;
					state <= SQ_INIT;
				end
				SQ_INIT: begin
					if (step_done) begin
						if (init_idx == 4'(`LCD_INIT_STEPS - 1)) begin
							screen <= game_state;
							index <= '0;
							state <= SQ_LOAD;
						end
						else begin
							init_idx <= init_idx + 4'd1;
							step <= init_entry(init_idx + 4'd1);
							step_start <= 1'b1;
						end
					end
				end
				// ROM output follows screen and index one cycle later
				SQ_LOAD: begin
					step <= rom_entry;
					step_start <= 1'b1;
					state <= SQ_STREAM;
				end
				SQ_STREAM: begin
					if (step_done) begin
						if (game_state != screen) begin
							screen <= game_state;
							index <= '0;
							state <= SQ_LOAD;
						end
						else if (rom_last) begin
							state <= SQ_IDLE;
						end
						else begin
							index <= index + 1'b1;
							state <= SQ_LOAD;
						end
					end
				end
				default: begin
					if (game_state != screen) begin
						screen <= game_state;
						index <= '0;
						state <= SQ_LOAD;
					end
				end
			endcase
		end
	end

	// Relies on the ROM flagging the last entry of every screen
	assert property (@(posedge clk) disable iff (reset)
		index < `LCD_SCREEN_MAX)
		else $error("screen index ran past the longest screen");

endmodule

// ==== design/lcd_controller.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_controller import lcd_pkg::*; (
	input logic clk,
	input logic reset,
	input screen_t game_state,
	output lcd_bus_t lcd
);

	lcd_step_t step;
	logic step_start;
	logic step_done;
	screen_t screen;
	logic [`LCD_INDEX_W-1:0] index;
	lcd_step_t rom_entry;
	logic rom_last;

	lcd_sequencer sequencer (
		.clk(clk),
		.reset(reset),
		.game_state(game_state),
		.step(step),
		.step_start(step_start),
		.step_done(step_done),
		.screen(screen),
		.index(index),
		.rom_entry(rom_entry),
		.rom_last(rom_last)
	);

	lcd_screen_rom rom (
		.screen(screen),
		.index(index),
		.entry(rom_entry),
		.last(rom_last)
	);

	lcd_bus_writer writer (
		.clk(clk),
		.reset(reset),
		.step(step),
		.step_start(step_start),
		.step_done(step_done),
		.lcd(lcd)
	);

endmodule

// ==== verif/lcd_bus_monitor.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_bus_monitor import lcd_pkg::*; (
	input logic clk,
	input logic reset,
	input lcd_bus_t lcd,
	output logic byte_valid,
	output logic [8:0] byte_out,
	output int pulse_count,
	output int error_count
);

	logic prev_e;
	// rs and data as seen while e is high
	logic [4:0] held;
	logic [3:0] upper;
	int high_cycles;
	int low_cycles;
	int hold_left;
	int nibble_count;

	always @(posedge clk) begin
		if (reset) begin
			prev_e <= 1'b0;
			held <= '0;
			upper <= '0;
			high_cycles <= 0;
			low_cycles <= 0;
			hold_left <= 0;
			nibble_count <= 0;
			byte_valid <= 1'b0;
			byte_out <= '0;
			pulse_count <= 0;
			error_count = 0;
		end
		else begin
			byte_valid <= 1'b0;
			prev_e <= lcd.e;
			if (lcd.e && !prev_e) begin
				held <= {lcd.rs, lcd.data};
				high_cycles <= 1;
				if (pulse_count > 0) begin
					assert (low_cycles >= `LCD_NIBBLE_GAP) else begin
						$display("MISMATCH nibble_gap: expected at least %0d cycles, actual %0d",
							`LCD_NIBBLE_GAP, low_cycles);
						error_count = error_count + 1;
					end
				end
			end
			else if (lcd.e) begin
				high_cycles <= high_cycles + 1;
				assert ({lcd.rs, lcd.data} == held) else begin
					$display("MISMATCH bus_stable_high: expected 0x%02h, actual 0x%02h",
						held, {lcd.rs, lcd.data});
					error_count = error_count + 1;
				end
			end
			else if (prev_e) begin
				// The LCD latches on this falling edge
				assert (high_cycles == `LCD_E_PULSE_CYCLES) else begin
					$display("MISMATCH e_pulse_width: expected %0d cycles, actual %0d",
						`LCD_E_PULSE_CYCLES, high_cycles);
					error_count = error_count + 1;
				end
				assert ({lcd.rs, lcd.data} == held) else begin
					$display("MISMATCH bus_hold: expected 0x%02h, actual 0x%02h",
						held, {lcd.rs, lcd.data});
					error_count = error_count + 1;
				end
				pulse_count <= pulse_count + 1;
				hold_left <= `LCD_HOLD_CYCLES - 1;
				low_cycles <= 1;
				nibble_count <= nibble_count + 1;
				// Four wake-up nibbles go out alone and bytes in pairs
				if (nibble_count < 4) begin
					byte_out <= {held[4], 4'h0, held[3:0]};
					byte_valid <= 1'b1;
				end
				else if (nibble_count % 2 == 0) begin
					upper <= held[3:0];
				end
				else begin
					byte_out <= {held[4], upper, held[3:0]};
					byte_valid <= 1'b1;
				end
			end
			else begin
				low_cycles <= low_cycles + 1;
				if (hold_left > 0) begin
					hold_left <= hold_left - 1;
					assert ({lcd.rs, lcd.data} == held) else begin
						$display("MISMATCH bus_hold: expected 0x%02h, actual 0x%02h",
							held, {lcd.rs, lcd.data});
						error_count = error_count + 1;
					end
				end
			end
		end
	end

endmodule

// ==== verif/lcd_controller_tb.sv ====
`timescale 1ns/1ns

`include "lcd_settings.svh"

module lcd_controller_tb import lcd_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS = 6;
	localparam longint BYTE_CYCLES = 2 * (`LCD_SETUP_CYCLES + `LCD_E_PULSE_CYCLES
		+ `LCD_HOLD_CYCLES + 2) + `LCD_NIBBLE_GAP + `LCD_CMD_WAIT;
	localparam longint SETTLE_SUM = `LCD_POWER_UP_WAIT + `LCD_WAKE1_WAIT + `LCD_WAKE2_WAIT
		+ `LCD_CMD_WAIT + `LCD_CLEAR_WAIT;
	localparam longint WATCHDOG_CYCLES = 2 * (SETTLE_SUM
		+ NUM_ROWS * `LCD_SCREEN_MAX * BYTE_CYCLES + NUM_ROWS * 2 * `LCD_CLEAR_WAIT);

	logic clk;
	logic reset;
	screen_t game_state;
	lcd_bus_t lcd;

	logic rx_valid;
	logic [8:0] rx_byte;
	int pulse_count;
	int mon_errors;
	logic [8:0] rx_q [$];

	////////////////////////////////////////////////////////////////////////////
	// Row table with expected bytes as {rs, value}
	////////////////////////////////////////////////////////////////////////////

	string row_name [NUM_ROWS];
	screen_t row_state [NUM_ROWS];
	int row_switch_after [NUM_ROWS];
	screen_t row_switch_state [NUM_ROWS];
	logic row_quiet [NUM_ROWS];
	int row_first [NUM_ROWS];
	int row_count;
	logic [8:0] exp_bytes [$];

	int tests_ok;
	int tests_bad;

	lcd_controller dut (
		.clk(clk),
		.reset(reset),
		.game_state(game_state),
		.lcd(lcd)
	);

	lcd_bus_monitor mon (
		.clk(clk),
		.reset(reset),
		.lcd(lcd),
		.byte_valid(rx_valid),
		.byte_out(rx_byte),
		.pulse_count(pulse_count),
		.error_count(mon_errors)
	);

	always @(posedge clk) begin
		if (rx_valid) begin
			rx_q.push_back(rx_byte);
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the LCD stream stalled before all rows finished");
		$display("Testbench failed");
		$finish;
	end

	task automatic add_row(input string name, input screen_t state, input int switch_after,
		input screen_t switch_state, input logic quiet);
		row_name[row_count] = name;
		row_state[row_count] = state;
		row_switch_after[row_count] = switch_after;
		row_switch_state[row_count] = switch_state;
		row_quiet[row_count] = quiet;
		row_first[row_count] = exp_bytes.size();
		row_count++;
	endtask

	// Appends the first limit bytes of a screen stream
	task automatic append_screen(input screen_t s, input int limit);
		logic [8:0] full [$];
		string top;
		string bottom;
		logic [7:0] digit;
		top = " BinToDec Spele ";
		bottom = "<Sakt           ";
		full.push_back(9'h002);
		if (s == SCREEN_TITLE) begin
			for (int i = 0; i < top.len(); i++) begin
				full.push_back({1'b1, top[i]});
			end
			full.push_back(9'h0C0);
			for (int i = 0; i < bottom.len(); i++) begin
				full.push_back({1'b1, bottom[i]});
			end
		end
		else begin
			case (s)
				SCREEN_TWO: digit = "2";
				SCREEN_THREE: digit = "3";
				default: digit = "4";
			endcase
			full.push_back({1'b1, digit});
		end
		for (int i = 0; i < limit && i < full.size(); i++) begin
			exp_bytes.push_back(full[i]);
		end
	endtask

	task automatic fill_table();
		row_count = 0;
		add_row("power_on", SCREEN_TITLE, 0, SCREEN_TITLE, 1'b0);
		exp_bytes.push_back(9'h003);
		exp_bytes.push_back(9'h003);
		exp_bytes.push_back(9'h003);
		exp_bytes.push_back(9'h002);
		exp_bytes.push_back(9'h028);
		exp_bytes.push_back(9'h006);
		exp_bytes.push_back(9'h00C);
		exp_bytes.push_back(9'h001);
		add_row("title", SCREEN_TITLE, 0, SCREEN_TITLE, 1'b1);
		append_screen(SCREEN_TITLE, `LCD_SCREEN_MAX);
		add_row("screen_two", SCREEN_TWO, 0, SCREEN_TWO, 1'b0);
		append_screen(SCREEN_TWO, `LCD_SCREEN_MAX);
		add_row("screen_three", SCREEN_THREE, 0, SCREEN_THREE, 1'b0);
		append_screen(SCREEN_THREE, `LCD_SCREEN_MAX);
		add_row("screen_four", SCREEN_FOUR, 0, SCREEN_FOUR, 1'b0);
		append_screen(SCREEN_FOUR, `LCD_SCREEN_MAX);
		// Switch after five title bytes
		add_row("title_cut", SCREEN_TITLE, 5, SCREEN_THREE, 1'b1);
		append_screen(SCREEN_TITLE, 5);
		append_screen(SCREEN_THREE, `LCD_SCREEN_MAX);
	endtask

	task automatic run_row(input int r);
		int last;
		int errors;
		int start_pulses;
		logic [8:0] got;
		logic [8:0] want;
		last = (r + 1 < row_count) ? row_first[r + 1] : exp_bytes.size();
		errors = 0;
		@(posedge clk);
		#2;
		game_state = row_state[r];
		for (int i = row_first[r]; i < last; i++) begin
			while (rx_q.size() == 0) begin
				@(negedge clk);
			end
			got = rx_q.pop_front();
			want = exp_bytes[i];
			assert (got == want) else begin
				$display("MISMATCH %s byte %0d: expected rs=%0b 0x%02h, actual rs=%0b 0x%02h",
					row_name[r], i - row_first[r], want[8], want[7:0], got[8], got[7:0]);
				errors++;
			end
			if (i - row_first[r] + 1 == row_switch_after[r]) begin
				@(posedge clk);
				#2;
				game_state = row_switch_state[r];
			end
		end
		if (row_quiet[r]) begin
			start_pulses = pulse_count;
			repeat (2 * `LCD_CLEAR_WAIT) @(negedge clk);
			assert (pulse_count == start_pulses && rx_q.size() == 0 && !lcd.e) else begin
				$display("%s: e pulsed during the quiet window after the stream", row_name[r]);
				errors++;
			end
		end
		if (errors == 0) begin
			tests_ok++;
		end
		else begin
			tests_bad++;
		end
		$display("test %s: %s, %0d bytes, %0d errors", row_name[r],
			(errors == 0) ? "ok" : "bad", last - row_first[r], errors);
	endtask

	initial begin
		reset = 1'b1;
		game_state = SCREEN_TITLE;
		tests_ok = 0;
		tests_bad = 0;
		fill_table();
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int r = 0; r < row_count; r++) begin
			run_row(r);
		end
		$display("tests %0d, ok %0d, bad %0d, bus timing errors %0d",
			row_count, tests_ok, tests_bad, mon_errors);
		if (tests_bad == 0 && mon_errors == 0) begin
			$display("Testbench passed");
		end
		else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== lcd_controller.f ====
+incdir+design
design/lcd_pkg.sv
design/lcd_delay_timer.sv
design/lcd_bus_writer.sv
design/lcd_screen_rom.sv
design/lcd_sequencer.sv
design/lcd_controller.sv
verif/lcd_bus_monitor.sv
verif/lcd_controller_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_controller

sources:
  - include_dirs:
      - design
    files:
      - design/lcd_pkg.sv
      - design/lcd_delay_timer.sv
      - design/lcd_bus_writer.sv
      - design/lcd_screen_rom.sv
      - design/lcd_sequencer.sv
      - design/lcd_controller.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/lcd_bus_monitor.sv
      - verif/lcd_controller_tb.sv
